// File: include/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Register and data path width
`define CSR_XLEN 32

// Privilege after reset, machine mode in the priv_e encoding
`define CSR_RESET_PRIV 2'b11

`endif

// File: hw/csr_pkg.sv
`include "csr_config.svh"

package csr_pkg;

  // Reserved encoding 2'b10 is never stored
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_e;

  typedef enum logic [11:0] {
    CSR_SSTATUS = 12'h100,
    CSR_SIE     = 12'h104,
    CSR_SEPC    = 12'h141,
    CSR_SCAUSE  = 12'h142,
    CSR_SIP     = 12'h144,
    CSR_MSTATUS = 12'h300,
    CSR_MIE     = 12'h304,
    CSR_MEPC    = 12'h341,
    CSR_MCAUSE  = 12'h342,
    CSR_MIP     = 12'h344
  } csr_addr_e;

  // mstatus field positions
  localparam int MSTATUS_SIE    = 1;
  localparam int MSTATUS_MIE    = 3;
  localparam int MSTATUS_SPIE   = 5;
  localparam int MSTATUS_MPIE   = 7;
  localparam int MSTATUS_SPP    = 8;
  localparam int MSTATUS_MPP_LO = 11;
  localparam int MSTATUS_MPP_HI = 12;
  localparam int MSTATUS_MPRV   = 17;

  // Interrupt bit in mip/mie, also the interrupt cause code
  localparam int IRQ_SSI = 1;
  localparam int IRQ_MSI = 3;
  localparam int IRQ_STI = 5;
  localparam int IRQ_MTI = 7;
  localparam int IRQ_SEI = 9;
  localparam int IRQ_MEI = 11;

  // Exception codes
  localparam int EXC_ILLEGAL = 2;
  localparam int EXC_ECALL_U = 8;
  localparam int EXC_ECALL_S = 9;
  localparam int EXC_ECALL_M = 11;

  typedef struct packed {
    logic                 en;
    csr_addr_e            addr;
    logic [`CSR_XLEN-1:0] data;
  } csr_write_t;

  typedef struct packed {
    logic       take;
    logic       interrupt;
    logic [4:0] cause;
    logic       mret;
    logic       sret;
  } trap_event_t;

  typedef struct packed {
    logic       valid;
    logic [4:0] code;
  } irq_request_t;

endpackage

// File: hw/trap_control.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module trap_control (
  input  logic                 clock,
  input  logic                 reset,
  input  csr_pkg::irq_request_t irq,
  input  logic                 illegal_instruction,
  input  logic                 ecall,
  input  logic                 mret,
  input  logic                 sret,
  input  csr_pkg::priv_e       mpp,
  input  logic                 spp,
  output csr_pkg::trap_event_t event_out,
  output csr_pkg::priv_e       priv
);

  import csr_pkg::*;

  // Interrupts first, then illegal instruction, then ecall
  always_comb begin
    event_out = '0;
    if (irq.valid) begin
      event_out.take      = 1'b1;
      event_out.interrupt = 1'b1;
      event_out.cause     = irq.code;
    end else if (illegal_instruction) begin
      event_out.take  = 1'b1;
      event_out.cause = 5'(EXC_ILLEGAL);
    end else if (ecall) begin
      event_out.take  = 1'b1;
      // U, S and M map onto codes 8, 9 and 11
      event_out.cause = 5'(EXC_ECALL_U) + 5'(priv);
    end else begin
      // Returns only when no trap, mret wins over sret
      event_out.mret = mret;
      event_out.sret = sret && !mret;
    end
  end

  // Privilege mode, every trap lands in machine mode
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      priv <= priv_e'(`CSR_RESET_PRIV);
    end else if (event_out.take) begin
      priv <= PRIV_M;
    end else if (event_out.mret) begin
      priv <= mpp;
    end else if (event_out.sret) begin
      priv <= spp ? PRIV_S : PRIV_U;
    end
  end

endmodule

// File: hw/status_regs.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module status_regs (
  input  logic                  clock,
  input  logic                  reset,
  input  csr_pkg::csr_write_t   wr,
  input  csr_pkg::trap_event_t  event_in,
  input  csr_pkg::priv_e        priv,
  output logic [`CSR_XLEN-1:0]  mstatus,
  output logic [`CSR_XLEN-1:0]  sstatus,
  output csr_pkg::priv_e        mpp,
  output logic                  spp,
  output logic                  mie_bit,
  output logic                  sie_bit
);

  import csr_pkg::*;

  logic mpie;
  logic spie;
  logic mprv;
  logic wr_ok;
  logic [1:0] wr_mpp;

  assign wr_ok  = wr.en && !event_in.take;
  assign wr_mpp = wr.data[MSTATUS_MPP_HI:MSTATUS_MPP_LO];

  // M fields and MPRV
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mie_bit <= 1'b0;
      mpie    <= 1'b0;
      mpp     <= PRIV_U;
      mprv    <= 1'b0;
    end else if (event_in.take) begin
      mpie    <= mie_bit;
      mie_bit <= 1'b0;
      mpp     <= priv;
    end else if (event_in.mret) begin
      mie_bit <= mpie;
      mpie    <= 1'b1;
      mpp     <= PRIV_U;
      if (mpp != PRIV_M) mprv <= 1'b0;
    end else if (event_in.sret) begin
      mprv <= 1'b0;
    end else if (wr_ok && wr.addr == CSR_MSTATUS) begin
      mie_bit <= wr.data[MSTATUS_MIE];
      mpie    <= wr.data[MSTATUS_MPIE];
      mprv    <= wr.data[MSTATUS_MPRV];
      // Reserved MPP encoding keeps the old value
      if (wr_mpp != 2'b10) mpp <= priv_e'(wr_mpp);
    end
  end

  // S fields, untouched by traps
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sie_bit <= 1'b0;
      spie    <= 1'b0;
      spp     <= 1'b0;
    end else if (event_in.sret) begin
      sie_bit <= spie;
      spie    <= 1'b1;
      spp     <= 1'b0;
    end else if (wr_ok && !event_in.mret &&
                 (wr.addr == CSR_MSTATUS || wr.addr == CSR_SSTATUS)) begin
      sie_bit <= wr.data[MSTATUS_SIE];
      spie    <= wr.data[MSTATUS_SPIE];
      spp     <= wr.data[MSTATUS_SPP];
    end
  end

  always_comb begin
    mstatus = '0;
    mstatus[MSTATUS_SIE]  = sie_bit;
    mstatus[MSTATUS_MIE]  = mie_bit;
    mstatus[MSTATUS_SPIE] = spie;
    mstatus[MSTATUS_MPIE] = mpie;
    mstatus[MSTATUS_SPP]  = spp;
    mstatus[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = mpp;
    mstatus[MSTATUS_MPRV] = mprv;
    // S view hides the M-only fields
    sstatus = mstatus;
    sstatus[MSTATUS_MIE]  = 1'b0;
    sstatus[MSTATUS_MPIE] = 1'b0;
    sstatus[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = 2'b00;
    sstatus[MSTATUS_MPRV] = 1'b0;
  end

endmodule

// File: hw/interrupt_unit.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module interrupt_unit (
  input  logic                  clock,
  input  logic                  reset,
  input  csr_pkg::csr_write_t   wr,
  input  csr_pkg::trap_event_t  event_in,
  input  csr_pkg::priv_e        priv,
  input  logic                  mie_bit,
  input  logic                  sie_bit,
  input  logic                  external_interrupt,
  input  logic                  mem_msip,
  input  logic                  mem_ssip,
  input  logic [63:0]           mem_mtime,
  input  logic [63:0]           mem_mtimecmp,
  output logic [`CSR_XLEN-1:0]  mip,
  output logic [`CSR_XLEN-1:0]  sip,
  output logic [`CSR_XLEN-1:0]  mie,
  output logic [`CSR_XLEN-1:0]  sie,
  output csr_pkg::irq_request_t irq
);

  import csr_pkg::*;

  localparam logic [`CSR_XLEN-1:0] M_IRQ_MASK = (1 << IRQ_MSI) | (1 << IRQ_MTI) | (1 << IRQ_MEI);
  localparam logic [`CSR_XLEN-1:0] S_IRQ_MASK = (1 << IRQ_SSI) | (1 << IRQ_STI) | (1 << IRQ_SEI);
  // Highest priority first
  localparam int IRQ_ORDER [6] = '{IRQ_MEI, IRQ_MTI, IRQ_MSI, IRQ_SEI, IRQ_STI, IRQ_SSI};

  logic stip;
  logic seip;
  logic wr_ok;
  logic pending_write;
  logic m_enable;
  logic s_enable;
  logic [`CSR_XLEN-1:0] active;

  assign wr_ok = wr.en && !event_in.take;
  // STIP and SEIP are writable from machine mode only
  assign pending_write = wr_ok && priv == PRIV_M &&
                         (wr.addr == CSR_MIP || wr.addr == CSR_SIP);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mie  <= '0;
      stip <= 1'b0;
      seip <= 1'b0;
    end else begin
      if (wr_ok && wr.addr == CSR_MIE) begin
        mie <= wr.data & (M_IRQ_MASK | S_IRQ_MASK);
      end else if (wr_ok && wr.addr == CSR_SIE) begin
        mie <= (mie & M_IRQ_MASK) | (wr.data & S_IRQ_MASK);
      end
      if (pending_write) begin
        stip <= wr.data[IRQ_STI];
        seip <= wr.data[IRQ_SEI];
      end
    end
  end

  always_comb begin
    mip = '0;
    mip[IRQ_SSI] = mem_ssip;
    mip[IRQ_MSI] = mem_msip;
    mip[IRQ_STI] = stip;
    mip[IRQ_MTI] = mem_mtime >= mem_mtimecmp;
    mip[IRQ_SEI] = seip;
    mip[IRQ_MEI] = external_interrupt;
  end

  assign sip = mip & S_IRQ_MASK;
  assign sie = mie & S_IRQ_MASK;

  // Global enables per level
  assign m_enable = (priv != PRIV_M) || mie_bit;
  assign s_enable = (priv == PRIV_U) || sie_bit;

  always_comb begin
    active = mip & mie & ((m_enable ? M_IRQ_MASK : '0) | (s_enable ? S_IRQ_MASK : '0));
    irq = '0;
    // Walk from lowest priority so the highest one wins
    for (int i = 5; i >= 0; i--) begin
      if (active[IRQ_ORDER[i]]) begin
        irq.valid = 1'b1;
        irq.code  = 5'(IRQ_ORDER[i]);
      end
    end
  end

endmodule

// File: hw/epc_cause_regs.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module epc_cause_regs (
  input  logic                  clock,
  input  logic                  reset,
  input  csr_pkg::csr_write_t   wr,
  input  csr_pkg::trap_event_t  event_in,
  input  logic [`CSR_XLEN-1:0]  pc,
  output logic [`CSR_XLEN-1:0]  mepc,
  output logic [`CSR_XLEN-1:0]  sepc,
  output logic [`CSR_XLEN-1:0]  mcause,
  output logic [`CSR_XLEN-1:0]  scause
);

  import csr_pkg::*;

  logic wr_ok;
  logic cause_legal;
  logic [`CSR_XLEN-1:0] trap_cause;
  logic [`CSR_XLEN-1:0] epc_value;

  // Only the listed interrupt and exception codes are kept
  function automatic logic is_legal_cause(input logic [`CSR_XLEN-1:0] value);
    logic [`CSR_XLEN-2:0] code;
    code = value[`CSR_XLEN-2:0];
    if (value[`CSR_XLEN-1]) begin
      return code == IRQ_SSI || code == IRQ_MSI || code == IRQ_STI ||
             code == IRQ_MTI || code == IRQ_SEI || code == IRQ_MEI;
    end
    return code == EXC_ILLEGAL || code == EXC_ECALL_U ||
           code == EXC_ECALL_S || code == EXC_ECALL_M;
  endfunction

  assign wr_ok       = wr.en && !event_in.take;
  assign cause_legal = is_legal_cause(wr.data);
  // Instruction addresses are word aligned
  assign epc_value   = {wr.data[`CSR_XLEN-1:2], 2'b00};

  always_comb begin
    trap_cause = '0;
    trap_cause[`CSR_XLEN-1] = event_in.interrupt;
    trap_cause[4:0] = event_in.cause;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mepc   <= '0;
      sepc   <= '0;
      mcause <= '0;
      scause <= '0;
    end else if (event_in.take) begin
      mepc   <= pc;
      mcause <= trap_cause;
    end else if (wr_ok) begin
      if (wr.addr == CSR_MEPC) mepc <= epc_value;
      if (wr.addr == CSR_SEPC) sepc <= epc_value;
      if (wr.addr == CSR_MCAUSE && cause_legal) mcause <= wr.data;
      if (wr.addr == CSR_SCAUSE && cause_legal) scause <= wr.data;
    end
  end

endmodule

// File: hw/csr_unit.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_unit (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 wr_en,
  input  logic [11:0]          addr,
  input  logic [`CSR_XLEN-1:0] wr_data,
  input  logic [`CSR_XLEN-1:0] pc,
  input  logic                 external_interrupt,
  input  logic                 mem_msip,
  input  logic                 mem_ssip,
  input  logic [63:0]          mem_mtime,
  input  logic [63:0]          mem_mtimecmp,
  input  logic                 illegal_instruction,
  input  logic                 ecall,
  input  logic                 mret,
  input  logic                 sret,
  output logic [`CSR_XLEN-1:0] rd_data,
  output logic [`CSR_XLEN-1:0] mepc,
  output logic [`CSR_XLEN-1:0] sepc,
  output logic                 trap,
  output csr_pkg::priv_e       privilege_mode
);

  import csr_pkg::*;

  csr_write_t           wr;
  trap_event_t          trap_event;
  irq_request_t         irq;
  priv_e                mpp;
  logic                 spp;
  logic                 mie_bit;
  logic                 sie_bit;
  logic [`CSR_XLEN-1:0] mstatus;
  logic [`CSR_XLEN-1:0] sstatus;
  logic [`CSR_XLEN-1:0] mip;
  logic [`CSR_XLEN-1:0] sip;
  logic [`CSR_XLEN-1:0] mie;
  logic [`CSR_XLEN-1:0] sie;
  logic [`CSR_XLEN-1:0] mcause;
  logic [`CSR_XLEN-1:0] scause;

  assign wr = '{en: wr_en, addr: csr_addr_e'(addr), data: wr_data};
  assign trap = trap_event.take;

  trap_control trap_control_inst (
    .clock(clock), .reset(reset), .irq(irq),
    .illegal_instruction(illegal_instruction), .ecall(ecall), .mret(mret), .sret(sret),
    .mpp(mpp), .spp(spp), .event_out(trap_event), .priv(privilege_mode)
  );

  status_regs status_regs_inst (
    .clock(clock), .reset(reset), .wr(wr), .event_in(trap_event), .priv(privilege_mode),
    .mstatus(mstatus), .sstatus(sstatus), .mpp(mpp), .spp(spp),
    .mie_bit(mie_bit), .sie_bit(sie_bit)
  );

  interrupt_unit interrupt_unit_inst (
    .clock(clock), .reset(reset), .wr(wr), .event_in(trap_event), .priv(privilege_mode),
    .mie_bit(mie_bit), .sie_bit(sie_bit), .external_interrupt(external_interrupt),
    .mem_msip(mem_msip), .mem_ssip(mem_ssip),
    .mem_mtime(mem_mtime), .mem_mtimecmp(mem_mtimecmp),
    .mip(mip), .sip(sip), .mie(mie), .sie(sie), .irq(irq)
  );

  epc_cause_regs epc_cause_regs_inst (
    .clock(clock), .reset(reset), .wr(wr), .event_in(trap_event), .pc(pc),
    .mepc(mepc), .sepc(sepc), .mcause(mcause), .scause(scause)
  );

  // Combinational read, unimplemented addresses give zero
  always_comb begin
    case (wr.addr)
      CSR_SSTATUS: rd_data = sstatus;
      CSR_SIE:     rd_data = sie;
      CSR_SEPC:    rd_data = sepc;
      CSR_SCAUSE:  rd_data = scause;
      CSR_SIP:     rd_data = sip;
      CSR_MSTATUS: rd_data = mstatus;
      CSR_MIE:     rd_data = mie;
      CSR_MEPC:    rd_data = mepc;
      CSR_MCAUSE:  rd_data = mcause;
      CSR_MIP:     rd_data = mip;
      default:     rd_data = '0;
    endcase
  end

endmodule

// File: verification/csr_unit_properties.sv
`timescale 1ns/1ps

module csr_unit_properties (
  input logic           clock,
  input logic           reset,
  input logic           trap,
  input csr_pkg::priv_e privilege_mode
);

  import csr_pkg::*;

  int unsigned failures = 0;

  // Every trap lands in machine mode
  trap_enters_machine: assert property (
    @(posedge clock) disable iff (reset) trap |=> privilege_mode == PRIV_M
  ) else begin
    failures++;
    $error("Privilege was not machine mode in the cycle after a trap");
  end

  // Reserved encoding never shows up
  no_reserved_priv: assert property (
    @(posedge clock) disable iff (reset) privilege_mode != 2'b10
  ) else begin
    failures++;
    $error("Privilege mode holds the reserved encoding");
  end

endmodule

// File: verification/csr_unit_tb.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_unit_tb;

  import csr_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam logic [63:0] MTIMECMP   = 64'h100;
  localparam logic [63:0] MTIME_IDLE = 64'h0;
  localparam logic [63:0] MTIME_HIT  = 64'h180;

  typedef enum logic [2:0] {
    OP_WRITE,
    OP_READ,
    OP_ECALL,
    OP_ILLEGAL,
    OP_MRET,
    OP_SRET,
    OP_IRQ
  } op_e;

  // Interrupt lines of one row
  typedef struct packed {
    logic ext;
    logic msip;
    logic ssip;
    logic timer;
  } irq_lines_t;

  localparam irq_lines_t LINES_IDLE      = 4'b0000;
  localparam irq_lines_t LINES_EXT_TIMER = 4'b1001;

  // exp_rd is compared on read rows only
  typedef struct packed {
    op_e                  op;
    logic [11:0]          addr;
    logic [`CSR_XLEN-1:0] data;
    logic [`CSR_XLEN-1:0] pc;
    irq_lines_t           lines;
    logic [`CSR_XLEN-1:0] exp_rd;
    logic                 exp_trap;
    priv_e                exp_priv;
  } row_t;

  logic                 clock;
  logic                 reset;
  logic                 wr_en;
  logic [11:0]          addr;
  logic [`CSR_XLEN-1:0] wr_data;
  logic [`CSR_XLEN-1:0] pc;
  logic                 external_interrupt;
  logic                 mem_msip;
  logic                 mem_ssip;
  logic [63:0]          mem_mtime;
  logic [63:0]          mem_mtimecmp;
  logic                 illegal_instruction;
  logic                 ecall;
  logic                 mret;
  logic                 sret;
  logic [`CSR_XLEN-1:0] rd_data;
  logic [`CSR_XLEN-1:0] mepc;
  logic [`CSR_XLEN-1:0] sepc;
  logic                 trap;
  priv_e                privilege_mode;

  row_t rows[$];
  int   errors;
  int   checks;
  int   cycles;
  int   cycle_limit;

  csr_unit csr_unit_inst (
    .clock(clock), .reset(reset), .wr_en(wr_en), .addr(addr), .wr_data(wr_data),
    .pc(pc), .external_interrupt(external_interrupt), .mem_msip(mem_msip),
    .mem_ssip(mem_ssip), .mem_mtime(mem_mtime), .mem_mtimecmp(mem_mtimecmp),
    .illegal_instruction(illegal_instruction), .ecall(ecall), .mret(mret), .sret(sret),
    .rd_data(rd_data), .mepc(mepc), .sepc(sepc), .trap(trap),
    .privilege_mode(privilege_mode)
  );

  bind csr_unit csr_unit_properties csr_unit_properties_inst (
    .clock(clock), .reset(reset), .trap(trap), .privilege_mode(privilege_mode)
  );

  always #10 clock = ~clock;

  task automatic add_row(input op_e op, input logic [11:0] a, input logic [31:0] data,
                         input logic [31:0] row_pc, input irq_lines_t lines,
                         input logic [31:0] exp_rd, input logic exp_trap, input priv_e exp_priv);
    rows.push_back('{op, a, data, row_pc, lines, exp_rd, exp_trap, exp_priv});
  endtask

  task automatic load_table();
    // Reset values
    add_row(OP_READ, CSR_SSTATUS, 32'h0, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_SIE, 32'h0, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_SEPC, 32'h0, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_SCAUSE, 32'h0, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_SIP, 32'h0, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MSTATUS, 32'h0, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MIE, 32'h0, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MEPC, 32'h0, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MCAUSE, 32'h0, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MIP, 32'h0, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    // mepc and sepc alignment, reserved MPP, sstatus view
    add_row(OP_WRITE, CSR_MEPC, 32'h1003, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MEPC, 32'h0, 32'h0, LINES_IDLE, 32'h1000, 1'b0, PRIV_M);
    add_row(OP_WRITE, CSR_SEPC, 32'h2006, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_SEPC, 32'h0, 32'h0, LINES_IDLE, 32'h2004, 1'b0, PRIV_M);
    add_row(OP_WRITE, CSR_MSTATUS, 32'h0808, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MSTATUS, 32'h0, 32'h0, LINES_IDLE, 32'h0808, 1'b0, PRIV_M);
    add_row(OP_WRITE, CSR_MSTATUS, 32'h1008, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MSTATUS, 32'h0, 32'h0, LINES_IDLE, 32'h0808, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_SSTATUS, 32'h0, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    // ecall from machine mode
    add_row(OP_ECALL, CSR_MSTATUS, 32'h0, 32'h80, LINES_IDLE, 32'h0, 1'b1, PRIV_M);
    add_row(OP_READ, CSR_MEPC, 32'h0, 32'h0, LINES_IDLE, 32'h80, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MCAUSE, 32'h0, 32'h0, LINES_IDLE, 32'hb, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MSTATUS, 32'h0, 32'h0, LINES_IDLE, 32'h1880, 1'b0, PRIV_M);
    // mret to S, ecall from S, sret to U, illegal from U
    add_row(OP_WRITE, CSR_MSTATUS, 32'h0800, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_MRET, CSR_MSTATUS, 32'h0, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_ECALL, CSR_MSTATUS, 32'h0, 32'h104, LINES_IDLE, 32'h0, 1'b1, PRIV_S);
    add_row(OP_READ, CSR_MCAUSE, 32'h0, 32'h0, LINES_IDLE, 32'h9, 1'b0, PRIV_M);
    add_row(OP_SRET, CSR_MSTATUS, 32'h0, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_ILLEGAL, CSR_MSTATUS, 32'h0, 32'h200, LINES_IDLE, 32'h0, 1'b1, PRIV_U);
    add_row(OP_READ, CSR_MCAUSE, 32'h0, 32'h0, LINES_IDLE, 32'h2, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MSTATUS, 32'h0, 32'h0, LINES_IDLE, 32'h20, 1'b0, PRIV_M);
    // MEI and MTI pending together, then MIE cleared by the trap
    add_row(OP_WRITE, CSR_MIE, 32'h880, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_WRITE, CSR_MSTATUS, 32'h8, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_IRQ, CSR_MIP, 32'h0, 32'h300, LINES_EXT_TIMER, 32'h0, 1'b1, PRIV_M);
    add_row(OP_READ, CSR_MCAUSE, 32'h0, 32'h0, LINES_EXT_TIMER, 32'h8000000b, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MIP, 32'h0, 32'h0, LINES_EXT_TIMER, 32'h880, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MEPC, 32'h0, 32'h0, LINES_EXT_TIMER, 32'h300, 1'b0, PRIV_M);
    // mcause legality, then an unimplemented address
    add_row(OP_WRITE, CSR_MCAUSE, 32'h5, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MCAUSE, 32'h0, 32'h0, LINES_IDLE, 32'h8000000b, 1'b0, PRIV_M);
    add_row(OP_WRITE, CSR_MCAUSE, 32'h80000007, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
    add_row(OP_READ, CSR_MCAUSE, 32'h0, 32'h0, LINES_IDLE, 32'h80000007, 1'b0, PRIV_M);
    add_row(OP_READ, 12'h305, 32'h0, 32'h0, LINES_IDLE, 32'h0, 1'b0, PRIV_M);
  endtask

  task automatic apply_row(input row_t r);
    wr_en               <= r.op == OP_WRITE;
    addr                <= r.addr;
    wr_data             <= r.data;
    pc                  <= r.pc;
    illegal_instruction <= r.op == OP_ILLEGAL;
    ecall               <= r.op == OP_ECALL;
    mret                <= r.op == OP_MRET;
    sret                <= r.op == OP_SRET;
    external_interrupt  <= r.lines.ext;
    mem_msip            <= r.lines.msip;
    mem_ssip            <= r.lines.ssip;
    mem_mtime           <= r.lines.timer ? MTIME_HIT : MTIME_IDLE;
  endtask

  // Sampled mid-cycle so privilege still shows the value before this row
  task automatic check_row(input int index, input row_t r);
    checks++;
    assert (trap === r.exp_trap) else begin
      errors++;
      $display("ERROR: row %0d trap got %h expected %h", index, trap, r.exp_trap);
    end
    assert (privilege_mode === r.exp_priv) else begin
      errors++;
      $display("ERROR: row %0d privilege_mode got %h expected %h",
               index, privilege_mode, r.exp_priv);
    end
    if (r.op == OP_READ) begin
      assert (rd_data === r.exp_rd) else begin
        errors++;
        $display("ERROR: row %0d rd_data got %h expected %h", index, rd_data, r.exp_rd);
      end
    end
    // The epc output ports carry the same registers as the read path
    if (r.op == OP_READ && r.addr == CSR_MEPC) begin
      assert (mepc === r.exp_rd) else begin
        errors++;
        $display("ERROR: row %0d mepc got %h expected %h", index, mepc, r.exp_rd);
      end
    end
    if (r.op == OP_READ && r.addr == CSR_SEPC) begin
      assert (sepc === r.exp_rd) else begin
        errors++;
        $display("ERROR: row %0d sepc got %h expected %h", index, sepc, r.exp_rd);
      end
    end
  endtask

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the table did not complete", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    wr_en = 1'b0;
    addr = '0;
    wr_data = '0;
    pc = '0;
    external_interrupt = 1'b0;
    mem_msip = 1'b0;
    mem_ssip = 1'b0;
    mem_mtime = MTIME_IDLE;
    mem_mtimecmp = MTIMECMP;
    illegal_instruction = 1'b0;
    ecall = 1'b0;
    mret = 1'b0;
    sret = 1'b0;
    errors = 0;
    checks = 0;
    cycles = 0;
    load_table();
    cycle_limit = rows.size() + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    foreach (rows[i]) begin
      @(posedge clock);
      apply_row(rows[i]);
      @(negedge clock);
      check_row(i, rows[i]);
    end
    // One more edge so the bound properties see the last row
    @(posedge clock);
    @(negedge clock);
    errors += csr_unit_inst.csr_unit_properties_inst.failures;
    $display("Rows checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
hw/csr_pkg.sv
hw/trap_control.sv
hw/status_regs.sv
hw/interrupt_unit.sv
hw/epc_cause_regs.sv
hw/csr_unit.sv
verification/csr_unit_properties.sv
verification/csr_unit_tb.sv

// File: Bender.yml
package:
  name: csr_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/csr_pkg.sv
      - hw/trap_control.sv
      - hw/status_regs.sv
      - hw/interrupt_unit.sv
      - hw/epc_cause_regs.sv
      - hw/csr_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/csr_unit_properties.sv
      - verification/csr_unit_tb.sv
